// File: eth_crc32.sv
`timescale 1ns/10ps
module eth_crc32 (
    input  logic           gmii_tx_clk_i,
    input  logic           rst_i,
    input  logic           clear_i,
    input  logic           en_i,
    input  eth_pkg::byte_t data_i,
    output logic [31:0]    crc_o
);

    import eth_pkg::*;

    logic [31:0] crc;

    // Reflected form of 04C11DB7, LSB of each byte first.
    function automatic logic [31:0] crc_byte(logic [31:0] c, byte_t d);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ d[i];
            r  = r >> 1;
            if (fb) begin
                r = r ^ 32'hEDB88320;
            end
        end
        return r;
    endfunction

    always_ff @(posedge gmii_tx_clk_i or posedge rst_i) begin
        if (rst_i) begin
            crc <= '1;
        end else if (clear_i) begin
            crc <= '1;
        end else if (en_i) begin
            crc <= crc_byte(crc, data_i);
        end
    end

    // Low byte goes out first.
    assign crc_o = ~{crc[7:0], crc[15:8], crc[23:16], crc[31:24]};

endmodule

// File: eth_pkg.sv
package eth_pkg;

    // Basic widths.
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] addr_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // One datagram handed from the segmenter to the frame builder.
    typedef struct packed {
        len_t len;
        logic last;
    } seg_desc_t;

    // Segmenter states.
    typedef enum logic [2:0] {
        SEG_IDLE,
        SEG_DOOR,
        SEG_START,
        SEG_FETCH,
        SEG_REST,
        SEG_DONE
    } seg_state_t;

    // Frame builder states.
    typedef enum logic [2:0] {
        FRM_IDLE,
        FRM_PREAMBLE,
        FRM_HEADER,
        FRM_PAYLOAD,
        FRM_PAD,
        FRM_FCS,
        FRM_GAP
    } frm_state_t;

    // MAC 14 + IPv4 20 + UDP 8.
    localparam int HDR_LEN      = 42;
    // Shorter payloads are zero padded to reach the 64 byte minimum.
    localparam int MIN_PAYLOAD  = 18;
    localparam int PREAMBLE_LEN = 8;
    localparam int IFG_LEN      = 12;
    // Header bytes still to go when payload is requested.
    localparam int REQ_LEAD     = 4;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam byte_t IP_TTL        = 8'h80;
    localparam byte_t IP_PROTO_UDP  = 8'h11;

endpackage

// File: payload_fifo.sv
`timescale 1ns/10ps
module payload_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic           gmii_tx_clk_i,
    input  logic           rst_i,
    input  logic           wr_i,
    input  eth_pkg::byte_t wdata_i,
    input  logic           rd_i,
    output eth_pkg::byte_t rdata_o,
    output logic           empty_o,
    output logic           full_o
);

    import eth_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t         mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign empty_o = (count == '0);
    assign full_o  = (count == (AW+1)'(FIFO_DEPTH));

    always_ff @(posedge gmii_tx_clk_i) begin
        if (wr_i) begin
            mem[wr_ptr] <= wdata_i;
        end
        if (rd_i) begin
            rdata_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge gmii_tx_clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_i, rd_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge gmii_tx_clk_i) disable iff (rst_i)
        wr_i |-> !full_o);

    // The builder's request lead must keep the FIFO ahead of every pop.
    a_no_underflow: assert property (@(posedge gmii_tx_clk_i) disable iff (rst_i)
        rd_i |-> !empty_o);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_udp_tx -o sim_udp_tx \
    && ./obj_dir/sim_udp_tx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

// File: tb_udp_tx.sv
`timescale 1ns/10ps
module tb_udp_tx;

    import eth_pkg::*;

    // The trace's segment size column must agree with this value.
    localparam int        SEG_LEN    = 64;
    localparam int        FIFO_DEPTH = 16;
    localparam mac_addr_t SRC_MAC    = 48'h02_1A_2B_3C_4D_5E;
    localparam mac_addr_t DST_MAC    = 48'h02_AA_BB_CC_DD_EE;
    localparam ip_addr_t  SRC_IP     = 32'h0A_00_00_05;
    localparam ip_addr_t  DST_IP     = 32'h0A_00_00_2A;
    localparam port_t     SRC_PORT   = 16'd5001;
    localparam port_t     DST_PORT   = 16'd6001;

    logic        gmii_tx_clk;
    logic        rst;
    logic        tx_send;
    addr_t       tx_addr;
    len_t        tx_len;
    logic        tx_done;
    addr_t       buf_addr;
    byte_t       buf_data;
    addr_t       last_addr;
    logic        gmii_tx_en;
    byte_t       gmii_txd;
    logic [31:0] lfsr;
    addr_t       t_addr[$];
    len_t        t_len[$];
    logic        load_error;
    logic        limit_ready;
    int          limit_cycles;
    int          pass_cnt;
    int          fail_cnt;
    int          err_cnt;

    udp_tx_top #(
        .SEG_LEN    (SEG_LEN),
        .FIFO_DEPTH (FIFO_DEPTH),
        .SRC_MAC    (SRC_MAC),
        .DST_MAC    (DST_MAC),
        .SRC_IP     (SRC_IP),
        .DST_IP     (DST_IP),
        .SRC_PORT   (SRC_PORT),
        .DST_PORT   (DST_PORT)
    ) i_dut (
        .gmii_tx_clk_i (gmii_tx_clk),
        .rst_i         (rst),
        .tx_send_i     (tx_send),
        .tx_addr_i     (tx_addr),
        .tx_len_i      (tx_len),
        .tx_done_o     (tx_done),
        .tx_addr_o     (buf_addr),
        .tx_data_i     (buf_data),
        .gmii_tx_en_o  (gmii_tx_en),
        .gmii_txd_o    (gmii_txd)
    );

    udp_tx_checker #(
        .SEG_LEN  (SEG_LEN),
        .SRC_MAC  (SRC_MAC),
        .DST_MAC  (DST_MAC),
        .SRC_IP   (SRC_IP),
        .DST_IP   (DST_IP),
        .SRC_PORT (SRC_PORT),
        .DST_PORT (DST_PORT)
    ) i_checker (
        .gmii_tx_clk_i (gmii_tx_clk),
        .rst_i         (rst),
        .tx_send_i     (tx_send),
        .tx_addr_i     (tx_addr),
        .tx_len_i      (tx_len),
        .tx_done_i     (tx_done),
        .gmii_tx_en_i  (gmii_tx_en),
        .gmii_txd_i    (gmii_txd),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt),
        .err_cnt_o     (err_cnt)
    );

    initial begin
        gmii_tx_clk = 1'b0;
        forever #10 gmii_tx_clk = ~gmii_tx_clk;
    end

    function automatic byte_t buffer_byte(addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int random_bits(int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // Buffer with one cycle of read latency.
    always begin
        @(posedge gmii_tx_clk);
        #2;
        buf_data  = buffer_byte(last_addr);
        last_addr = buf_addr;
    end

    task automatic load_trace();
        int    fd;
        int    n;
        int    len;
        int    seg;
        addr_t a;
        string line;
        fd = $fopen("udp_tx_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file udp_tx_trace.txt");
            load_error = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %d %d", a, len, seg);
            if (n != 3) begin
                continue;
            end
            if (seg != SEG_LEN) begin
                $display("Trace segment size %0d does not match SEG_LEN %0d", seg, SEG_LEN);
                load_error = 1'b1;
            end
            t_addr.push_back(a);
            t_len.push_back(len_t'(len));
        end
        $fclose(fd);
    endtask

    task automatic run_test(addr_t a, len_t l);
        int gap;
        @(posedge gmii_tx_clk);
        #2;
        tx_addr = a;
        tx_len  = l;
        tx_send = 1'b1;
        do begin
            @(posedge gmii_tx_clk);
            #2;
        end while (!tx_done);
        tx_send = 1'b0;
        do begin
            @(posedge gmii_tx_clk);
            #2;
        end while (tx_done);
        gap = random_bits(4);
        repeat (gap + 1) @(posedge gmii_tx_clk);
    endtask

    initial begin
        int total;
        int frames;
        rst          = 1'b1;
        tx_send      = 1'b0;
        tx_addr      = '0;
        tx_len       = '0;
        buf_data     = '0;
        last_addr    = '0;
        lfsr         = 32'h83e3;
        load_error   = 1'b0;
        limit_ready  = 1'b0;
        limit_cycles = 0;
        load_trace();
        total = 0;
        foreach (t_len[i]) begin
            frames = (int'(t_len[i]) + SEG_LEN - 1) / SEG_LEN;
            total += frames * (PREAMBLE_LEN + HDR_LEN + SEG_LEN + 4 + IFG_LEN + 4) + 8;
        end
        limit_cycles = 2 * total + 40 * t_len.size() + 500;
        limit_ready  = 1'b1;
        repeat (5) @(posedge gmii_tx_clk);
        #2;
        rst = 1'b0;
        repeat (3) @(posedge gmii_tx_clk);
        if (!load_error) begin
            foreach (t_addr[i]) begin
                run_test(t_addr[i], t_len[i]);
            end
        end
        repeat (20) @(posedge gmii_tx_clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 t_addr.size(), pass_cnt, fail_cnt, err_cnt);
        if (!load_error && t_addr.size() > 0 && err_cnt == 0 && fail_cnt == 0 &&
            pass_cnt == t_addr.size()) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge gmii_tx_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: udp_frame_tx.sv
`timescale 1ns/10ps
module udp_frame_tx #(
    parameter int                 SEG_LEN  = 1400,
    parameter eth_pkg::mac_addr_t SRC_MAC  = 48'h02_00_00_00_00_01,
    parameter eth_pkg::mac_addr_t DST_MAC  = 48'h02_00_00_00_00_02,
    parameter eth_pkg::ip_addr_t  SRC_IP   = 32'hC0_A8_16_C8,
    parameter eth_pkg::ip_addr_t  DST_IP   = 32'hC0_A8_16_64,
    parameter eth_pkg::port_t     SRC_PORT = 16'h1F90,
    parameter eth_pkg::port_t     DST_PORT = 16'h1F90
) (
    input  logic               gmii_tx_clk_i,
    input  logic               rst_i,
    input  logic               seg_start_i,
    input  eth_pkg::seg_desc_t seg_i,
    output logic               payload_req_o,
    output logic               fifo_rd_o,
    input  eth_pkg::byte_t     fifo_rdata_i,
    output logic               frame_done_o,
    output logic               gmii_tx_en_o,
    output eth_pkg::byte_t     gmii_txd_o
);

    import eth_pkg::*;

    localparam int MAX_PAY   = (SEG_LEN > MIN_PAYLOAD) ? SEG_LEN : MIN_PAYLOAD;
    localparam int MAX_FRAME = PREAMBLE_LEN + HDR_LEN + MAX_PAY + 4;

    frm_state_t             state;
    len_t                   cnt;
    len_t                   pay_len;
    logic [15:0]            ip_id;
    logic [15:0]            ip_csum;
    logic [HDR_LEN*8-1:0]   hdr;
    byte_t                  txd_n;
    logic                   en_n;
    logic                   crc_en;
    logic [31:0]            crc_fcs;
    logic [15:0]            en_run;

    // One's-complement sum of the IPv4 header words, checksum field taken as zero.
    function automatic logic [15:0] ip_checksum(len_t plen, logic [15:0] id);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(plen + 16'd28) + 32'(id) + 32'h4000
            + {16'h0, IP_TTL, IP_PROTO_UDP}
            + 32'(SRC_IP[31:16]) + 32'(SRC_IP[15:0])
            + 32'(DST_IP[31:16]) + 32'(DST_IP[15:0]);
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        return ~sum[15:0];
    endfunction

    assign hdr = {DST_MAC, SRC_MAC, ETH_TYPE_IPV4,
                  8'h45, 8'h00, pay_len + 16'd28, ip_id, 16'h4000,
                  IP_TTL, IP_PROTO_UDP, ip_csum, SRC_IP, DST_IP,
                  SRC_PORT, DST_PORT, pay_len + 16'd8, 16'h0000};

    assign payload_req_o = (state == FRM_HEADER) && (cnt == len_t'(HDR_LEN - REQ_LEAD));
    // Pop one cycle ahead since FIFO data is registered.
    assign fifo_rd_o     = ((state == FRM_HEADER) && (cnt == len_t'(HDR_LEN - 1))) ||
                           ((state == FRM_PAYLOAD) && (cnt != pay_len - 16'd1));
    assign frame_done_o  = (state == FRM_GAP) && (cnt == len_t'(IFG_LEN - 1));
    assign crc_en        = (state == FRM_HEADER) || (state == FRM_PAYLOAD) ||
                           (state == FRM_PAD);

    always_comb begin
        txd_n = 8'h00;
        en_n  = 1'b1;
        case (state)
            FRM_PREAMBLE: txd_n = (cnt == len_t'(PREAMBLE_LEN - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
            FRM_HEADER:   txd_n = hdr[8*(HDR_LEN - 1 - int'(cnt[5:0])) +: 8];
            FRM_PAYLOAD:  txd_n = fifo_rdata_i;
            FRM_PAD:      txd_n = 8'h00;
            FRM_FCS:      txd_n = crc_fcs[31 - 8*int'(cnt[1:0]) -: 8];
            default:      en_n  = 1'b0;
        endcase
    end

    always_ff @(posedge gmii_tx_clk_i or posedge rst_i) begin
        if (rst_i) begin
            state   <= FRM_IDLE;
            cnt     <= '0;
            pay_len <= '0;
            ip_id   <= '0;
            ip_csum <= '0;
        end else begin
            cnt <= cnt + 16'd1;
            case (state)
                FRM_IDLE: begin
                    cnt <= '0;
                    if (seg_start_i) begin
                        pay_len <= seg_i.len;
                        ip_csum <= ip_checksum(seg_i.len, ip_id);
                        state   <= FRM_PREAMBLE;
                    end
                end
                FRM_PREAMBLE: begin
                    if (cnt == len_t'(PREAMBLE_LEN - 1)) begin
                        cnt   <= '0;
                        state <= FRM_HEADER;
                    end
                end
                FRM_HEADER: begin
                    if (cnt == len_t'(HDR_LEN - 1)) begin
                        cnt   <= '0;
                        state <= FRM_PAYLOAD;
                    end
                end
                FRM_PAYLOAD: begin
                    // Short payloads keep counting through the pad bytes.
                    if (cnt == pay_len - 16'd1) begin
                        if (pay_len < len_t'(MIN_PAYLOAD)) begin
                            state <= FRM_PAD;
                        end else begin
                            cnt   <= '0;
                            state <= FRM_FCS;
                        end
                    end
                end
                FRM_PAD: begin
                    if (cnt == len_t'(MIN_PAYLOAD - 1)) begin
                        cnt   <= '0;
                        state <= FRM_FCS;
                    end
                end
                FRM_FCS: begin
                    if (cnt == 16'd3) begin
                        cnt   <= '0;
                        state <= FRM_GAP;
                    end
                end
                FRM_GAP: begin
                    if (cnt == len_t'(IFG_LEN - 1)) begin
                        ip_id <= ip_id + 16'd1;
                        state <= FRM_IDLE;
                    end
                end
                default: state <= FRM_IDLE;
            endcase
        end
    end

    always_ff @(posedge gmii_tx_clk_i or posedge rst_i) begin
        if (rst_i) begin
            gmii_tx_en_o <= 1'b0;
            gmii_txd_o   <= '0;
        end else begin
            gmii_tx_en_o <= en_n;
            gmii_txd_o   <= txd_n;
        end
    end

    eth_crc32 i_crc (
        .gmii_tx_clk_i (gmii_tx_clk_i),
        .rst_i         (rst_i),
        .clear_i       (seg_start_i),
        .en_i          (crc_en),
        .data_i        (txd_n),
        .crc_o         (crc_fcs)
    );

    // Cycles the enable has already been high.
    always_ff @(posedge gmii_tx_clk_i or posedge rst_i) begin
        if (rst_i) begin
            en_run <= '0;
        end else if (gmii_tx_en_o) begin
            en_run <= en_run + 16'd1;
        end else begin
            en_run <= '0;
        end
    end

    a_frame_len: assert property (@(posedge gmii_tx_clk_i) disable iff (rst_i)
        gmii_tx_en_o |-> en_run < 16'(MAX_FRAME));

endmodule

// File: udp_segmenter.sv
`timescale 1ns/10ps
module udp_segmenter #(
    parameter int SEG_LEN = 1400
) (
    input  logic               gmii_tx_clk_i,
    input  logic               rst_i,
    input  logic               tx_send_i,
    input  eth_pkg::addr_t     tx_addr_i,
    input  eth_pkg::len_t      tx_len_i,
    input  eth_pkg::byte_t     tx_data_i,
    output eth_pkg::addr_t     tx_addr_o,
    output logic               tx_done_o,
    output logic               seg_start_o,
    output eth_pkg::seg_desc_t seg_o,
    input  logic               payload_req_i,
    input  logic               frame_done_i,
    output logic               fifo_wr_o,
    output eth_pkg::byte_t     fifo_wdata_o
);

    import eth_pkg::*;

    seg_state_t state;
    len_t       remaining;
    len_t       fetch_cnt;
    len_t       seg_len_n;

    // Full segment unless only the remainder is left.
    assign seg_len_n = (remaining > len_t'(SEG_LEN)) ? len_t'(SEG_LEN) : remaining;

    assign tx_done_o    = (state == SEG_DONE);
    // Buffer data returns one cycle after its address, already aligned with fifo_wr_o.
    assign fifo_wdata_o = tx_data_i;

    always_ff @(posedge gmii_tx_clk_i or posedge rst_i) begin
        if (rst_i) begin
            state       <= SEG_IDLE;
            remaining   <= '0;
            fetch_cnt   <= '0;
            tx_addr_o   <= '0;
            seg_o       <= '0;
            seg_start_o <= 1'b0;
            fifo_wr_o   <= 1'b0;
        end else begin
            seg_start_o <= 1'b0;
            fifo_wr_o   <= (state == SEG_FETCH);
            case (state)
                SEG_IDLE: begin
                    if (tx_send_i) begin
                        remaining <= tx_len_i;
                        tx_addr_o <= tx_addr_i;
                        state     <= SEG_DOOR;
                    end
                end
                SEG_DOOR: begin
                    if (remaining == '0) begin
                        state <= SEG_DONE;
                    end else begin
                        seg_o.len   <= seg_len_n;
                        seg_o.last  <= (remaining <= len_t'(SEG_LEN));
                        remaining   <= remaining - seg_len_n;
                        seg_start_o <= 1'b1;
                        state       <= SEG_START;
                    end
                end
                SEG_START: begin
                    if (payload_req_i) begin
                        fetch_cnt <= '0;
                        state     <= SEG_FETCH;
                    end
                end
                SEG_FETCH: begin
                    tx_addr_o <= tx_addr_o + 16'd1;
                    fetch_cnt <= fetch_cnt + 16'd1;
                    if (fetch_cnt == seg_o.len - 16'd1) begin
                        state <= SEG_REST;
                    end
                end
                SEG_REST: begin
                    // Only one frame in flight, so wait for the gap to end.
                    if (frame_done_i) begin
                        state <= seg_o.last ? SEG_DONE : SEG_DOOR;
                    end
                end
                SEG_DONE: begin
                    if (!tx_send_i) begin
                        state <= SEG_IDLE;
                    end
                end
                default: state <= SEG_IDLE;
            endcase
        end
    end

    // Every descriptor carries between one and SEG_LEN bytes.
    a_seg_len: assert property (@(posedge gmii_tx_clk_i) disable iff (rst_i)
        seg_start_o |-> (seg_o.len != '0) && (seg_o.len <= len_t'(SEG_LEN)));

    // A request for payload only comes while a descriptor is outstanding.
    a_req_in_start: assert property (@(posedge gmii_tx_clk_i) disable iff (rst_i)
        payload_req_i |-> state == SEG_START);

endmodule

// File: udp_tx_checker.sv
`timescale 1ns/10ps
module udp_tx_checker #(
    parameter int                 SEG_LEN  = 1400,
    parameter eth_pkg::mac_addr_t SRC_MAC  = 48'h02_00_00_00_00_01,
    parameter eth_pkg::mac_addr_t DST_MAC  = 48'h02_00_00_00_00_02,
    parameter eth_pkg::ip_addr_t  SRC_IP   = 32'hC0_A8_16_C8,
    parameter eth_pkg::ip_addr_t  DST_IP   = 32'hC0_A8_16_64,
    parameter eth_pkg::port_t     SRC_PORT = 16'h1F90,
    parameter eth_pkg::port_t     DST_PORT = 16'h1F90
) (
    input  logic           gmii_tx_clk_i,
    input  logic           rst_i,
    input  logic           tx_send_i,
    input  eth_pkg::addr_t tx_addr_i,
    input  eth_pkg::len_t  tx_len_i,
    input  logic           tx_done_i,
    input  logic           gmii_tx_en_i,
    input  eth_pkg::byte_t gmii_txd_i,
    output int             pass_cnt_o,
    output int             fail_cnt_o,
    output int             err_cnt_o
);

    import eth_pkg::*;

    byte_t       frame[$];
    byte_t       expect_q[$];
    logic        in_frame;
    logic        had_frame;
    logic        test_active;
    logic        send_q;
    logic        done_q;
    logic        have_id;
    logic [15:0] next_id;
    addr_t       test_addr;
    addr_t       cur_addr;
    int          test_len;
    int          remaining;
    int          exp_frames;
    int          frames_seen;
    int          idle_run;
    int          done_low_run;
    int          test_num;
    int          err_at_start;

    function automatic byte_t buffer_byte(addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic logic [31:0] crc_update(logic [31:0] c, byte_t d);
        logic [31:0] r;
        r = c ^ {24'h0, d};
        for (int k = 0; k < 8; k++) begin
            r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
        end
        return r;
    endfunction

    // IPv4 header checksum with its own field taken as zero.
    function automatic logic [15:0] header_checksum(logic [15:0] total, logic [15:0] id);
        logic [31:0] s;
        s = 32'h4500 + {16'h0, total} + {16'h0, id} + 32'h4000
            + {16'h0, IP_TTL, IP_PROTO_UDP}
            + {16'h0, SRC_IP[31:16]} + {16'h0, SRC_IP[15:0]}
            + {16'h0, DST_IP[31:16]} + {16'h0, DST_IP[15:0]};
        while (s[31:16] != 16'h0) begin
            s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        end
        return ~s[15:0];
    endfunction

    task automatic value_error(string sig, logic [31:0] got, logic [31:0] want);
        $display("error: %s got 0x%0h expected 0x%0h", sig, got, want);
        err_cnt_o++;
    endtask

    task automatic plain_error(string msg);
        $display("check failed: %s", msg);
        err_cnt_o++;
    endtask

    // Big-endian field, most significant byte first on the wire.
    task automatic push_field(logic [47:0] v, int n);
        for (int k = n - 1; k >= 0; k--) begin
            expect_q.push_back(v[8*k +: 8]);
        end
    endtask

    task automatic check_frame();
        int          seg;
        int          pad;
        int          total;
        int          bad;
        logic [15:0] id;
        logic [31:0] crc;
        frames_seen++;
        if (!test_active || remaining == 0) begin
            plain_error("a frame was sent with no payload left in the request");
            return;
        end
        seg = (remaining > SEG_LEN) ? SEG_LEN : remaining;
        pad = (seg < MIN_PAYLOAD) ? MIN_PAYLOAD - seg : 0;
        total = PREAMBLE_LEN + HDR_LEN + seg + pad + 4;
        remaining -= seg;
        if (frame.size() != total) begin
            value_error("gmii_tx_en high cycles", frame.size(), total);
            cur_addr += addr_t'(seg);
            return;
        end
        id = have_id ? next_id : {frame[26], frame[27]};
        expect_q.delete();
        for (int k = 0; k < PREAMBLE_LEN - 1; k++) begin
            expect_q.push_back(8'h55);
        end
        expect_q.push_back(8'hD5);
        push_field(DST_MAC, 6);
        push_field(SRC_MAC, 6);
        push_field(48'h0800, 2);
        push_field(48'h4500, 2);
        push_field(48'(seg + 28), 2);
        push_field({32'h0, id}, 2);
        push_field(48'h4000, 2);
        push_field({32'h0, IP_TTL, IP_PROTO_UDP}, 2);
        push_field({32'h0, header_checksum(16'(seg + 28), id)}, 2);
        push_field({16'h0, SRC_IP}, 4);
        push_field({16'h0, DST_IP}, 4);
        push_field({32'h0, SRC_PORT}, 2);
        push_field({32'h0, DST_PORT}, 2);
        push_field(48'(seg + 8), 2);
        push_field(48'h0, 2);
        for (int k = 0; k < seg; k++) begin
            expect_q.push_back(buffer_byte(cur_addr + addr_t'(k)));
        end
        for (int k = 0; k < pad; k++) begin
            expect_q.push_back(8'h00);
        end
        crc = 32'hFFFFFFFF;
        for (int k = PREAMBLE_LEN; k < total - 4; k++) begin
            crc = crc_update(crc, frame[k]);
        end
        crc = ~crc;
        // FCS leaves low byte first.
        push_field({16'h0, crc[7:0], crc[15:8], crc[23:16], crc[31:24]}, 4);
        bad = 0;
        for (int k = 0; k < total; k++) begin
            if (frame[k] != expect_q[k]) begin
                bad++;
                if (bad <= 4) begin
                    value_error($sformatf("gmii_txd frame %0d byte %0d", frames_seen, k),
                                {24'h0, frame[k]}, {24'h0, expect_q[k]});
                end
            end
        end
        cur_addr += addr_t'(seg);
        next_id = id + 16'd1;
        have_id = 1'b1;
    endtask

    task automatic start_test();
        test_addr    = tx_addr_i;
        test_len     = int'(tx_len_i);
        cur_addr     = tx_addr_i;
        remaining    = int'(tx_len_i);
        exp_frames   = (int'(tx_len_i) + SEG_LEN - 1) / SEG_LEN;
        frames_seen  = 0;
        err_at_start = err_cnt_o;
        test_active  = 1'b1;
    endtask

    task automatic finish_test();
        if (!test_active) begin
            plain_error("tx_done_o rose with no request pending");
            return;
        end
        if (frames_seen != exp_frames) begin
            value_error("frame count at tx_done_o", frames_seen, exp_frames);
        end
        if (exp_frames != 0 && (in_frame || idle_run < IFG_LEN)) begin
            plain_error("tx_done_o rose before the last interframe gap had ended");
        end
        test_num++;
        if (err_cnt_o == err_at_start) begin
            pass_cnt_o++;
        end else begin
            fail_cnt_o++;
        end
        $display("test %0d: addr 0x%04h len %0d frames %0d %s", test_num, test_addr,
                 test_len, frames_seen, (err_cnt_o == err_at_start) ? "ok" : "mismatch");
        test_active = 1'b0;
    endtask

    // Everything is sampled on the falling edge, half a cycle away from any change.
    always @(negedge gmii_tx_clk_i) begin
        if (rst_i) begin
            frame.delete();
            in_frame     = 1'b0;
            had_frame    = 1'b0;
            test_active  = 1'b0;
            send_q       = 1'b0;
            done_q       = 1'b0;
            have_id      = 1'b0;
            next_id      = '0;
            idle_run     = 0;
            done_low_run = 0;
            test_num     = 0;
            pass_cnt_o   = 0;
            fail_cnt_o   = 0;
            err_cnt_o    = 0;
        end else begin
            if (tx_send_i && !send_q) begin
                start_test();
            end
            if (gmii_tx_en_i) begin
                if (!in_frame && had_frame && idle_run < IFG_LEN) begin
                    value_error("gmii_tx_en idle cycles between frames", idle_run, IFG_LEN);
                end
                frame.push_back(gmii_txd_i);
                in_frame = 1'b1;
            end else if (in_frame) begin
                check_frame();
                frame.delete();
                in_frame  = 1'b0;
                had_frame = 1'b1;
                idle_run  = 1;
            end else begin
                idle_run++;
            end
            if (tx_done_i && !done_q) begin
                finish_test();
            end
            if (done_q && !tx_done_i && tx_send_i) begin
                plain_error("tx_done_o fell while tx_send_i was still high");
            end
            if (tx_done_i && !tx_send_i) begin
                done_low_run++;
                if (done_low_run == 3) begin
                    plain_error("tx_done_o stayed high after tx_send_i fell");
                end
            end else begin
                done_low_run = 0;
            end
            send_q = tx_send_i;
            done_q = tx_done_i;
        end
    end

endmodule

// File: udp_tx_top.sv
`timescale 1ns/10ps
module udp_tx_top #(
    parameter int                 SEG_LEN    = 1400,
    parameter int                 FIFO_DEPTH = 16,
    parameter eth_pkg::mac_addr_t SRC_MAC    = 48'h02_00_00_00_00_01,
    parameter eth_pkg::mac_addr_t DST_MAC    = 48'h02_00_00_00_00_02,
    parameter eth_pkg::ip_addr_t  SRC_IP     = 32'hC0_A8_16_C8,
    parameter eth_pkg::ip_addr_t  DST_IP     = 32'hC0_A8_16_64,
    parameter eth_pkg::port_t     SRC_PORT   = 16'h1F90,
    parameter eth_pkg::port_t     DST_PORT   = 16'h1F90
) (
    input  logic           gmii_tx_clk_i,
    input  logic           rst_i,
    input  logic           tx_send_i,
    input  eth_pkg::addr_t tx_addr_i,
    input  eth_pkg::len_t  tx_len_i,
    output logic           tx_done_o,
    output eth_pkg::addr_t tx_addr_o,
    input  eth_pkg::byte_t tx_data_i,
    output logic           gmii_tx_en_o,
    output eth_pkg::byte_t gmii_txd_o
);

    import eth_pkg::*;

    logic      seg_start;
    seg_desc_t seg;
    logic      payload_req;
    logic      frame_done;
    logic      fifo_wr;
    byte_t     fifo_wdata;
    logic      fifo_rd;
    byte_t     fifo_rdata;

    udp_segmenter #(
        .SEG_LEN (SEG_LEN)
    ) i_segmenter (
        .gmii_tx_clk_i (gmii_tx_clk_i),
        .rst_i         (rst_i),
        .tx_send_i     (tx_send_i),
        .tx_addr_i     (tx_addr_i),
        .tx_len_i      (tx_len_i),
        .tx_data_i     (tx_data_i),
        .tx_addr_o     (tx_addr_o),
        .tx_done_o     (tx_done_o),
        .seg_start_o   (seg_start),
        .seg_o         (seg),
        .payload_req_i (payload_req),
        .frame_done_i  (frame_done),
        .fifo_wr_o     (fifo_wr),
        .fifo_wdata_o  (fifo_wdata)
    );

    // Flags only feed the FIFO's own checks.
    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .gmii_tx_clk_i (gmii_tx_clk_i),
        .rst_i         (rst_i),
        .wr_i          (fifo_wr),
        .wdata_i       (fifo_wdata),
        .rd_i          (fifo_rd),
        .rdata_o       (fifo_rdata),
        .empty_o       (),
        .full_o        ()
    );

    udp_frame_tx #(
        .SEG_LEN  (SEG_LEN),
        .SRC_MAC  (SRC_MAC),
        .DST_MAC  (DST_MAC),
        .SRC_IP   (SRC_IP),
        .DST_IP   (DST_IP),
        .SRC_PORT (SRC_PORT),
        .DST_PORT (DST_PORT)
    ) i_frame_tx (
        .gmii_tx_clk_i (gmii_tx_clk_i),
        .rst_i         (rst_i),
        .seg_start_i   (seg_start),
        .seg_i         (seg),
        .payload_req_o (payload_req),
        .fifo_rd_o     (fifo_rd),
        .fifo_rdata_i  (fifo_rdata),
        .frame_done_o  (frame_done),
        .gmii_tx_en_o  (gmii_tx_en_o),
        .gmii_txd_o    (gmii_txd_o)
    );

endmodule

// File: udp_tx_trace.txt
# Columns: start address (hex), length in bytes (decimal), segment size (decimal)
# The segment size must match SEG_LEN in tb_udp_tx.
0000 1 64
0100 0 64
0010 17 64
0123 18 64
0200 19 64
1234 63 64
4000 64 64
8001 65 64
00ff 130 64
fff0 100 64
a5a5 7 64
3c3c 257 64
beef 0 64

// File: verilog.f
eth_pkg.sv
eth_crc32.sv
payload_fifo.sv
udp_segmenter.sv
udp_frame_tx.sv
udp_tx_top.sv
udp_tx_checker.sv
tb_udp_tx.sv
